/* verilog/cim_pkg.sv */
// CiM node package with widths, bus encodings, memory map and FSM states
`default_nettype none

package cim_pkg;

    // Fixed-point format
    localparam int N_STORAGE = 16;
    localparam int N_COMP = 22;
    localparam int FRAC_BITS = 10;

    typedef logic signed [N_STORAGE-1:0] storage_t;
    typedef logic signed [N_COMP-1:0] comp_t;

    // Shared bus
    localparam int NUM_CIMS = 4;
    localparam int BUS_LANES = 3;

    typedef logic [$clog2(NUM_CIMS)-1:0] node_id_t;

    typedef enum logic [3:0] {
        NOP,
        PATCH_LOAD_BROADCAST_START_OP,
        PATCH_LOAD_BROADCAST_OP,
        DENSE_BROADCAST_START_OP,
        DENSE_BROADCAST_DATA_OP,
        PARAM_STREAM_START_OP,
        PARAM_STREAM_OP
    } bus_op_t;

    // Memories
    localparam int INT_RES_DEPTH = 64;
    localparam int PARAMS_DEPTH = 64;

    typedef logic [$clog2(INT_RES_DEPTH)-1:0] int_res_addr_t;
    typedef logic [$clog2(PARAMS_DEPTH)-1:0] params_addr_t;

    localparam int PATCH_LEN = 8;
    localparam int NUM_PATCHES = 4;

    typedef logic [$clog2(PATCH_LEN+1)-1:0] mac_len_t;

    // Two patch buffers used in turn
    localparam int_res_addr_t [1:0] PATCH_SLOT_BASE = {6'd8, 6'd0};
    localparam int_res_addr_t PATCH_OUT_BASE = 6'd16;   // One projected value per patch
    localparam params_addr_t KERNEL_BASE = 6'd0;
    localparam params_addr_t BIAS_ADDR = 6'd8;

    typedef enum logic [2:0] {
        MAC_IDLE,
        MAC_READ,
        MAC_ACC,
        MAC_BIAS_READ,
        MAC_BIAS_ADD
    } mac_state_t;

    typedef enum logic {
        PROJ_IDLE,
        PROJ_MAC
    } proj_state_t;

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_READ,
        FILL_LATCH
    } fill_state_t;

endpackage

`default_nettype wire

/* verilog/cim_mem_if.sv */
// One requester port into a CiM memory array
`timescale 1ns/1ps
`default_nettype none

interface cim_mem_if import cim_pkg::*; #(
    parameter type addr_t = int_res_addr_t
) ();

    logic read_en;
    logic write_en;
    addr_t addr;
    storage_t write_data;
    storage_t read_data;    // Valid one cycle after read_en

    modport requester (
        output read_en, write_en, addr, write_data,
        input read_data
    );

    modport memory (
        input read_en, write_en, addr, write_data,
        output read_data
    );

endinterface

`default_nettype wire

/* verilog/cim_mem.sv */
// Parameter and intermediate-result storage with shared registered read ports
`timescale 1ns/1ps
`default_nettype none

module cim_mem import cim_pkg::*; (
    input logic clk,
    cim_mem_if.memory int_rx,
    cim_mem_if.memory int_proj,
    cim_mem_if.memory int_mac,
    cim_mem_if.memory int_tx,
    cim_mem_if.memory par_rx,
    cim_mem_if.memory par_mac
);

    storage_t int_res [INT_RES_DEPTH];
    storage_t params [PARAMS_DEPTH];
    storage_t int_rd_q;
    storage_t par_rd_q;
    int_res_addr_t int_rd_addr;

    assign int_rd_addr = int_mac.read_en ? int_mac.addr : int_tx.addr;

    always_ff @(posedge clk) begin
        // Writers own disjoint regions
        if (int_rx.write_en) begin
            int_res[int_rx.addr] <= int_rx.write_data;
        end
        if (int_proj.write_en) begin
            int_res[int_proj.addr] <= int_proj.write_data;
        end
        if (par_rx.write_en) begin
            params[par_rx.addr] <= par_rx.write_data;
        end
        if (int_mac.read_en || int_tx.read_en) begin
            int_rd_q <= int_res[int_rd_addr];
        end
        if (par_mac.read_en) begin
            par_rd_q <= params[par_mac.addr];
        end
    end

    assign int_mac.read_data = int_rd_q;
    assign int_tx.read_data = int_rd_q;
    assign int_rx.read_data = int_rd_q;
    assign int_proj.read_data = int_rd_q;
    assign par_mac.read_data = par_rd_q;
    assign par_rx.read_data = par_rd_q;

    // MAC and send share the int_res read port
    assert property (@(posedge clk) not (int_mac.read_en && int_tx.read_en))
        else $error("int_res read by MAC and send in the same cycle");

    assert property (@(posedge clk)
        not (int_rx.write_en && int_proj.write_en && int_rx.addr == int_proj.addr))
        else $error("int_res writers hit the same address");

endmodule

`default_nettype wire

/* verilog/mac_engine.sv */
// Sequential fixed-point multiply-accumulate with bias and truncation to storage width
`timescale 1ns/1ps
`default_nettype none

module mac_engine import cim_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic mac_start,
    input  mac_len_t len,
    input  int_res_addr_t addr1,
    input  params_addr_t addr2,
    input  params_addr_t bias_addr,
    cim_mem_if.requester int_rd,
    cim_mem_if.requester par_rd,
    output logic mac_busy,
    output logic mac_done,
    output storage_t mac_result
);

    mac_state_t state;
    mac_len_t len_q;
    mac_len_t cnt;
    int_res_addr_t addr1_q;
    params_addr_t addr2_q;
    params_addr_t bias_q;
    comp_t acc;
    comp_t sum;
    logic signed [2*N_STORAGE-1:0] prod;

    assign int_rd.read_en = (state == MAC_READ);
    assign int_rd.write_en = 1'b0;
    assign int_rd.addr = addr1_q + int_res_addr_t'(cnt);
    assign int_rd.write_data = '0;

    assign par_rd.read_en = (state == MAC_READ) || (state == MAC_BIAS_READ);
    assign par_rd.write_en = 1'b0;
    assign par_rd.addr = (state == MAC_BIAS_READ) ? bias_q : addr2_q + params_addr_t'(cnt);
    assign par_rd.write_data = '0;

    assign prod = int_rd.read_data * par_rd.read_data;
    assign sum = acc + comp_t'(par_rd.read_data);  // Bias sign-extended
    assign mac_busy = (state != MAC_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= MAC_IDLE;
            mac_done <= 1'b0;
        end else begin
            mac_done <= 1'b0;
            case (state)
                MAC_IDLE: begin
                    if (mac_start) begin
                        len_q <= len;
                        addr1_q <= addr1;
                        addr2_q <= addr2;
                        bias_q <= bias_addr;
                        cnt <= '0;
                        acc <= '0;
                        state <= MAC_READ;
                    end
                end
                MAC_READ: state <= MAC_ACC;
                MAC_ACC: begin
                    acc <= acc + comp_t'(prod >>> FRAC_BITS);  // Wraps in comp_t
                    cnt <= cnt + 1'b1;
                    state <= (cnt == len_q - 1'b1) ? MAC_BIAS_READ : MAC_READ;
                end
                MAC_BIAS_READ: state <= MAC_BIAS_ADD;
                MAC_BIAS_ADD: begin
                    // Two's-complement low bits equal the sign-magnitude cut
                    mac_result <= storage_t'(sum[N_STORAGE-1:0]);
                    mac_done <= 1'b1;
                    state <= MAC_IDLE;
                end
                default: state <= MAC_IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) mac_start |-> !mac_busy)
        else $error("mac_start while the MAC is busy");

endmodule

`default_nettype wire

/* verilog/bus_rx_ctrl.sv */
// Bus instruction decoder for parameter streaming, patch loading and send requests
`timescale 1ns/1ps
`default_nettype none

module bus_rx_ctrl import cim_pkg::*; #(
    parameter node_id_t NODE_ID = '0
) (
    input  logic clk,
    input  logic rst_n,
    input  bus_op_t bus_op,
    input  storage_t [BUS_LANES-1:0] bus_data,
    input  node_id_t bus_target_or_sender,
    cim_mem_if.requester int_wr,
    cim_mem_if.requester par_wr,
    output logic patch_ready,
    output int_res_addr_t patch_slot,
    output logic load_start,
    output logic tx_start,
    output int_res_addr_t tx_addr,
    output logic [1:0] tx_words
);

    logic to_me;
    params_addr_t rx_addr;
    params_addr_t rx_cnt;
    logic [1:0] lane;
    logic [$clog2(PATCH_LEN)-1:0] word_idx;
    logic slot;
    logic last_word;

    assign to_me = (bus_target_or_sender == NODE_ID);
    assign int_wr.read_en = 1'b0;
    assign par_wr.read_en = 1'b0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            int_wr.write_en <= 1'b0;
            par_wr.write_en <= 1'b0;
            patch_ready <= 1'b0;
            load_start <= 1'b0;
            tx_start <= 1'b0;
            last_word <= 1'b0;
            rx_cnt <= '0;
            lane <= '0;
            word_idx <= '0;
            slot <= 1'b0;
        end else begin
            int_wr.write_en <= 1'b0;
            par_wr.write_en <= 1'b0;
            load_start <= 1'b0;
            tx_start <= 1'b0;
            last_word <= 1'b0;
            patch_ready <= last_word;  // After the last word lands
            if (last_word) begin
                patch_slot <= int_wr.addr - int_res_addr_t'(PATCH_LEN - 1);
            end
            case (bus_op)
                PARAM_STREAM_START_OP: begin
                    rx_addr <= params_addr_t'(bus_data[0]);
                    rx_cnt <= '0;
                    lane <= '0;
                end
                PARAM_STREAM_OP: begin
                    // Master fills lanes 0, 1, 2 in turn
                    if (to_me) begin
                        par_wr.write_en <= 1'b1;
                        par_wr.addr <= rx_addr + rx_cnt;
                        par_wr.write_data <= bus_data[lane];
                        rx_cnt <= rx_cnt + 1'b1;
                        lane <= (lane == 2'd2) ? 2'd0 : lane + 1'b1;
                    end
                end
                PATCH_LOAD_BROADCAST_START_OP: begin
                    load_start <= 1'b1;
                    word_idx <= '0;
                    slot <= 1'b0;
                end
                PATCH_LOAD_BROADCAST_OP: begin
                    int_wr.write_en <= 1'b1;
                    int_wr.addr <= PATCH_SLOT_BASE[slot] + int_res_addr_t'(word_idx);
                    int_wr.write_data <= bus_data[0];
                    word_idx <= word_idx + 1'b1;
                    if (word_idx == PATCH_LEN - 1) begin
                        last_word <= 1'b1;
                        slot <= ~slot;  // Next patch into the other buffer
                    end
                end
                DENSE_BROADCAST_START_OP: begin
                    if (to_me) begin
                        tx_start <= 1'b1;
                        tx_addr <= int_res_addr_t'(bus_data[0]);
                        tx_words <= bus_data[1][1:0];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // A send carries one to three words
    assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> tx_words != 2'd0)
        else $error("Send requested with zero words");

endmodule

`default_nettype wire

/* verilog/patch_proj_ctrl.sv */
// Patch projection sequencer that runs one MAC per patch and stores its result
`timescale 1ns/1ps
`default_nettype none

module patch_proj_ctrl import cim_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic patch_ready,
    input  int_res_addr_t patch_slot,
    input  logic load_start,
    input  logic mac_busy,
    input  logic mac_done,
    input  storage_t mac_result,
    input  logic tx_busy,
    cim_mem_if.requester int_wr,
    output logic mac_start,
    output mac_len_t mac_len,
    output int_res_addr_t mac_addr1,
    output params_addr_t mac_addr2,
    output params_addr_t mac_bias_addr,
    output logic is_ready
);

    proj_state_t state;
    logic [$clog2(NUM_PATCHES+1)-1:0] patch_idx;
    logic all_done;

    // Every patch uses the same kernel and bias
    assign mac_len = mac_len_t'(PATCH_LEN);
    assign mac_addr2 = KERNEL_BASE;
    assign mac_bias_addr = BIAS_ADDR;
    assign int_wr.read_en = 1'b0;

    assign is_ready = all_done & ~mac_busy & ~tx_busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= PROJ_IDLE;
            mac_start <= 1'b0;
            int_wr.write_en <= 1'b0;
            patch_idx <= '0;
            all_done <= 1'b0;
        end else begin
            mac_start <= 1'b0;
            int_wr.write_en <= 1'b0;
            if (int_wr.write_en && patch_idx == NUM_PATCHES) begin
                all_done <= 1'b1;
            end
            case (state)
                PROJ_IDLE: begin
                    if (patch_ready) begin
                        mac_start <= 1'b1;
                        mac_addr1 <= patch_slot;
                        state <= PROJ_MAC;
                    end
                end
                PROJ_MAC: begin
                    if (mac_done) begin
                        int_wr.write_en <= 1'b1;
                        int_wr.addr <= PATCH_OUT_BASE + int_res_addr_t'(patch_idx);
                        int_wr.write_data <= mac_result;
                        patch_idx <= patch_idx + 1'b1;
                        state <= PROJ_IDLE;
                    end
                end
                default: state <= PROJ_IDLE;
            endcase
            if (load_start) begin  // New image
                patch_idx <= '0;
                all_done <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/bus_tx_fill.sv */
// Fill-and-send FSM that gathers stored words into bus lanes and drives one instruction
`timescale 1ns/1ps
`default_nettype none

module bus_tx_fill import cim_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic tx_start,
    input  int_res_addr_t tx_addr,
    input  logic [1:0] tx_words,
    cim_mem_if.requester int_rd,
    output logic tx_busy,
    output logic bus_drive,
    output bus_op_t bus_out_op,
    output storage_t [BUS_LANES-1:0] bus_out_data
);

    fill_state_t state;
    int_res_addr_t base;
    logic [1:0] words;
    logic [1:0] idx;
    logic [1:0] lane;

    // Short sends are right-aligned to lane 2
    assign lane = idx + (2'(BUS_LANES) - words);

    assign int_rd.read_en = (state == FILL_READ);
    assign int_rd.write_en = 1'b0;
    assign int_rd.addr = base + int_res_addr_t'(idx);
    assign int_rd.write_data = '0;

    assign tx_busy = (state != FILL_IDLE);
    assign bus_out_op = bus_drive ? DENSE_BROADCAST_DATA_OP : NOP;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= FILL_IDLE;
            bus_drive <= 1'b0;
        end else begin
            bus_drive <= 1'b0;
            case (state)
                FILL_IDLE: begin
                    if (tx_start) begin
                        base <= tx_addr;
                        words <= tx_words;
                        idx <= '0;
                        bus_out_data <= '0;  // Unused lanes stay zero
                        state <= FILL_READ;
                    end
                end
                FILL_READ: state <= FILL_LATCH;
                FILL_LATCH: begin
                    bus_out_data[lane] <= int_rd.read_data;
                    idx <= idx + 1'b1;
                    if (idx == words - 1'b1) begin
                        bus_drive <= 1'b1;
                        state <= FILL_IDLE;
                    end else begin
                        state <= FILL_READ;
                    end
                end
                default: state <= FILL_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/cim_node.sv */
// CiM node top level with bus decode, patch projection and dense send
`timescale 1ns/1ps
`default_nettype none

module cim_node import cim_pkg::*; #(
    parameter node_id_t NODE_ID = '0
) (
    input  logic clk,
    input  logic rst_n,
    input  bus_op_t bus_op,
    input  storage_t [BUS_LANES-1:0] bus_data,
    input  node_id_t bus_target_or_sender,
    output bus_op_t bus_out_op,
    output storage_t [BUS_LANES-1:0] bus_out_data,
    output node_id_t bus_out_target_or_sender,
    output logic bus_drive,
    output logic is_ready
);

    logic patch_ready;
    logic load_start;
    logic tx_start;
    logic tx_busy;
    logic mac_start;
    logic mac_busy;
    logic mac_done;
    logic [1:0] tx_words;
    int_res_addr_t patch_slot;
    int_res_addr_t tx_addr;
    int_res_addr_t mac_addr1;
    params_addr_t mac_addr2;
    params_addr_t mac_bias_addr;
    mac_len_t mac_len;
    storage_t mac_result;

    cim_mem_if int_rx_if ();
    cim_mem_if int_proj_if ();
    cim_mem_if int_mac_if ();
    cim_mem_if int_tx_if ();
    cim_mem_if #(.addr_t(params_addr_t)) par_rx_if ();
    cim_mem_if #(.addr_t(params_addr_t)) par_mac_if ();

    assign bus_out_target_or_sender = NODE_ID;  // Always the sender

    cim_mem u_cim_mem (
        .clk(clk),
        .int_rx(int_rx_if.memory),
        .int_proj(int_proj_if.memory),
        .int_mac(int_mac_if.memory),
        .int_tx(int_tx_if.memory),
        .par_rx(par_rx_if.memory),
        .par_mac(par_mac_if.memory)
    );

    bus_rx_ctrl #(.NODE_ID(NODE_ID)) u_bus_rx_ctrl (
        .clk(clk),
        .rst_n(rst_n),
        .bus_op(bus_op),
        .bus_data(bus_data),
        .bus_target_or_sender(bus_target_or_sender),
        .int_wr(int_rx_if.requester),
        .par_wr(par_rx_if.requester),
        .patch_ready(patch_ready),
        .patch_slot(patch_slot),
        .load_start(load_start),
        .tx_start(tx_start),
        .tx_addr(tx_addr),
        .tx_words(tx_words)
    );

    patch_proj_ctrl u_patch_proj_ctrl (
        .clk(clk),
        .rst_n(rst_n),
        .patch_ready(patch_ready),
        .patch_slot(patch_slot),
        .load_start(load_start),
        .mac_busy(mac_busy),
        .mac_done(mac_done),
        .mac_result(mac_result),
        .tx_busy(tx_busy),
        .int_wr(int_proj_if.requester),
        .mac_start(mac_start),
        .mac_len(mac_len),
        .mac_addr1(mac_addr1),
        .mac_addr2(mac_addr2),
        .mac_bias_addr(mac_bias_addr),
        .is_ready(is_ready)
    );

    mac_engine u_mac_engine (
        .clk(clk),
        .rst_n(rst_n),
        .mac_start(mac_start),
        .len(mac_len),
        .addr1(mac_addr1),
        .addr2(mac_addr2),
        .bias_addr(mac_bias_addr),
        .int_rd(int_mac_if.requester),
        .par_rd(par_mac_if.requester),
        .mac_busy(mac_busy),
        .mac_done(mac_done),
        .mac_result(mac_result)
    );

    bus_tx_fill u_bus_tx_fill (
        .clk(clk),
        .rst_n(rst_n),
        .tx_start(tx_start),
        .tx_addr(tx_addr),
        .tx_words(tx_words),
        .int_rd(int_tx_if.requester),
        .tx_busy(tx_busy),
        .bus_drive(bus_drive),
        .bus_out_op(bus_out_op),
        .bus_out_data(bus_out_data)
    );

endmodule

`default_nettype wire

/* test/tb_clk_gen.sv */
// Testbench clock and synchronous reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;  // Released on a clock edge
    end

endmodule

`default_nettype wire

/* test/cim_node_tb.sv */
// Testbench for the CiM node covering parameter streaming, patch projection and dense send
`timescale 1ns/1ps
`default_nettype none

module cim_node_tb import cim_pkg::*; ();

    localparam node_id_t MY_ID = 2'd1;
    localparam int PATCH_GAP = 2 * PATCH_LEN + 4;  // Next patch waits out the MAC
    localparam int WAIT_LIMIT = 200;
    localparam int QUIET_WINDOW = 20;

    logic clk;
    logic rst_n;
    bus_op_t bus_op;
    storage_t [BUS_LANES-1:0] bus_data;
    node_id_t bus_target_or_sender;
    bus_op_t bus_out_op;
    storage_t [BUS_LANES-1:0] bus_out_data;
    node_id_t bus_out_target_or_sender;
    logic bus_drive;
    logic is_ready;

    logic [31:0] lfsr_state = 32'h811c;
    storage_t param_words [PATCH_LEN+1];  // Kernel words, then bias
    storage_t patch_words [NUM_PATCHES*PATCH_LEN];

    tb_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(16)) u_clk_gen (
        .clk(clk),
        .rst_n(rst_n)
    );

    cim_node #(.NODE_ID(MY_ID)) u_cim_node (
        .clk(clk),
        .rst_n(rst_n),
        .bus_op(bus_op),
        .bus_data(bus_data),
        .bus_target_or_sender(bus_target_or_sender),
        .bus_out_op(bus_out_op),
        .bus_out_data(bus_out_data),
        .bus_out_target_or_sender(bus_out_target_or_sender),
        .bus_drive(bus_drive),
        .is_ready(is_ready)
    );

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [15:0] draw(input int nbits);
        logic [15:0] v;
        v = '0;
        for (int b = 0; b < nbits; b++) begin
            v = {v[14:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    // Roughly +-2.0 in Q5.10
    function automatic storage_t small_word();
        logic [15:0] raw;
        raw = draw(12);
        return {{4{raw[11]}}, raw[11:0]};
    endfunction

    function automatic storage_t expected_proj(input int p);
        logic signed [31:0] prod;
        comp_t acc;
        comp_t mag;
        storage_t bias;
        storage_t low;
        acc = '0;
        for (int i = 0; i < PATCH_LEN; i++) begin
            prod = patch_words[p*PATCH_LEN+i] * param_words[i];
            prod = prod >>> FRAC_BITS;
            acc = acc + prod[N_COMP-1:0];  // Wraps at compute width
        end
        bias = param_words[PATCH_LEN];
        acc = acc + {{(N_COMP-N_STORAGE){bias[N_STORAGE-1]}}, bias};
        mag = acc[N_COMP-1] ? -acc : acc;
        low = mag[N_STORAGE-1:0];
        return acc[N_COMP-1] ? -low : low;
    endfunction

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort($sformatf("[ERROR] time %0t %s expected %h actual %h",
                            $time, name, expected, actual));
        end
    endtask

    task automatic drive_bus(input bus_op_t op, input node_id_t target,
                             input storage_t d0, input storage_t d1, input storage_t d2);
        @(posedge clk);
        bus_op <= op;
        bus_target_or_sender <= target;
        bus_data <= {d2, d1, d0};
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) drive_bus(NOP, 2'd0, '0, '0, '0);
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            abort("Reset was never released");
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!is_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!is_ready) begin
            abort("is_ready did not rise after the patches were loaded");
        end
    endtask

    task automatic request_send(input int addr, input int words, input node_id_t target);
        drive_bus(DENSE_BROADCAST_START_OP, target, storage_t'(addr), storage_t'(words), '0);
        idle(1);
    endtask

    task automatic expect_send(input string what, input storage_t e0, input storage_t e1,
                               input storage_t e2);
        int n;
        n = 0;
        @(negedge clk);
        while (!bus_drive && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!bus_drive) begin
            abort({"No bus_drive pulse for the ", what});
        end
        check_value("bus_out_op", 32'(DENSE_BROADCAST_DATA_OP), 32'(bus_out_op));
        check_value("bus_out_target_or_sender", 32'(MY_ID), 32'(bus_out_target_or_sender));
        check_value("bus_out_data[0]", 32'(e0), 32'(bus_out_data[0]));
        check_value("bus_out_data[1]", 32'(e1), 32'(bus_out_data[1]));
        check_value("bus_out_data[2]", 32'(e2), 32'(bus_out_data[2]));
        @(negedge clk);
        check_value("bus_drive", 32'd0, 32'(bus_drive));  // One cycle only
    endtask

    task automatic stream_params();
        storage_t lanes [BUS_LANES];
        drive_bus(PARAM_STREAM_START_OP, MY_ID, storage_t'(KERNEL_BASE), '0, '0);
        for (int k = 0; k <= PATCH_LEN; k++) begin
            param_words[k] = small_word();
            for (int j = 0; j < BUS_LANES; j++) begin
                lanes[j] = storage_t'(draw(16));
            end
            lanes[k % BUS_LANES] = param_words[k];
            drive_bus(PARAM_STREAM_OP, MY_ID, lanes[0], lanes[1], lanes[2]);
            // Traffic for node 2 must be dropped
            drive_bus(PARAM_STREAM_OP, 2'd2, ~param_words[k], ~param_words[k], ~param_words[k]);
        end
        idle(1);
    endtask

    task automatic load_patches();
        storage_t w;
        for (int p = 0; p < NUM_PATCHES; p++) begin
            for (int i = 0; i < PATCH_LEN; i++) begin
                w = storage_t'(draw(16));
                patch_words[p*PATCH_LEN+i] = w;
                drive_bus(PATCH_LOAD_BROADCAST_OP, 2'd0, w, ~w, w ^ 16'h00ff);  // Lane 0 only
            end
            idle(PATCH_GAP);
        end
    endtask

    initial begin
        bus_op = NOP;
        bus_data = '0;
        bus_target_or_sender = '0;
        wait_reset();

        repeat (10) begin
            @(negedge clk);
            check_value("bus_drive", 32'd0, 32'(bus_drive));
            check_value("is_ready", 32'd0, 32'(is_ready));
        end

        stream_params();
        drive_bus(PATCH_LOAD_BROADCAST_START_OP, 2'd0, '0, '0, '0);
        idle(1);
        load_patches();
        wait_ready();

        request_send(PATCH_OUT_BASE, 3, MY_ID);
        expect_send("three-word send", expected_proj(0), expected_proj(1), expected_proj(2));
        request_send(PATCH_OUT_BASE + 3, 1, MY_ID);
        expect_send("one-word send", '0, '0, expected_proj(3));
        request_send(PATCH_OUT_BASE + 2, 2, MY_ID);
        expect_send("two-word send", '0, expected_proj(2), expected_proj(3));

        // Request for another node stays silent
        request_send(PATCH_OUT_BASE, 3, 2'd3);
        repeat (QUIET_WINDOW) begin
            @(negedge clk);
            check_value("bus_drive", 32'd0, 32'(bus_drive));
        end

        drive_bus(PATCH_LOAD_BROADCAST_START_OP, 2'd0, '0, '0, '0);
        idle(1);
        repeat (3) @(negedge clk);
        check_value("is_ready", 32'd0, 32'(is_ready));
        load_patches();
        wait_ready();
        request_send(PATCH_OUT_BASE, 3, MY_ID);
        expect_send("second image send", expected_proj(0), expected_proj(1), expected_proj(2));
        request_send(PATCH_OUT_BASE + 3, 1, MY_ID);
        expect_send("second image last word", '0, '0, expected_proj(3));

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
verilog/cim_pkg.sv
verilog/cim_mem_if.sv
verilog/cim_mem.sv
verilog/mac_engine.sv
verilog/bus_rx_ctrl.sv
verilog/patch_proj_ctrl.sv
verilog/bus_tx_fill.sv
verilog/cim_node.sv
test/tb_clk_gen.sv
test/cim_node_tb.sv

/* Bender.yml */
package:
  name: cim_node

sources:
  - files:
      - verilog/cim_pkg.sv
      - verilog/cim_mem_if.sv
      - verilog/cim_mem.sv
      - verilog/mac_engine.sv
      - verilog/bus_rx_ctrl.sv
      - verilog/patch_proj_ctrl.sv
      - verilog/bus_tx_fill.sv
      - verilog/cim_node.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/cim_node_tb.sv
